// ==== ahb_pkg.sv ====
package ahb_pkg;

   // --------------------
   // bus geometry
   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int NUM_MASTERS = 2;
   localparam int NUM_SLAVES  = 4;
   localparam int MASTER_ID_W = 4;

   // --------------------
   // address map, index = slave number before remap
   localparam logic [ADDR_W-1:0] REGION_START [NUM_SLAVES] = '{
      32'h0000_0000,
      32'h2000_0000,
      32'h4000_0000,
      32'h8000_0000
   };
   localparam logic [ADDR_W-1:0] REGION_SIZE [NUM_SLAVES] = '{
      32'h2000_0000,
      32'h2000_0000,
      32'h4000_0000,
      32'h4000_0000
   };

   // --------------------
   // encodings
   typedef enum logic [1:0] {
      TRANS_IDLE   = 2'b00,
      TRANS_BUSY   = 2'b01,
      TRANS_NONSEQ = 2'b10,
      TRANS_SEQ    = 2'b11
   } htrans_e;

   typedef enum logic [1:0] {
      RESP_OKAY  = 2'b00,
      RESP_ERROR = 2'b01,
      RESP_RETRY = 2'b10,
      RESP_SPLIT = 2'b11
   } hresp_e;

   typedef enum logic {
      ARB_READY = 1'b0,   // bus free
      ARB_STAY  = 1'b1    // bus owned
   } arb_state_e;

   typedef enum logic [1:0] {
      DSLV_IDLE      = 2'b00,
      DSLV_WRITE_ERR = 2'b01,
      DSLV_READ_ERR  = 2'b10
   } dslv_state_e;

   // address-phase control from a master
   typedef struct packed {
      logic [ADDR_W-1:0] haddr;
      htrans_e           htrans;
      logic [2:0]        hsize;
      logic [2:0]        hburst;
      logic [3:0]        hprot;
      logic              hwrite;
   } ahb_ctrl_t;

   // slave response back to the masters
   typedef struct packed {
      logic [DATA_W-1:0] hrdata;
      hresp_e            hresp;
      logic              hready;
   } ahb_resp_t;

endpackage

// ==== ahb_arbiter.sv ====
`timescale 1ns/1ns

module ahb_arbiter import ahb_pkg::*; (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  logic [NUM_MASTERS-1:0] hbusreq,   // bit 0 has highest priority
   input  logic [NUM_MASTERS-1:0] hlock,
   input  logic                   hready,
   output logic [NUM_MASTERS-1:0] hgrant,
   output logic [MASTER_ID_W-1:0] hmaster,
   output logic                   hmastlock
);

   arb_state_e             state;
   logic [NUM_MASTERS-1:0] hmask;      // 1 = masked out
   logic [NUM_MASTERS-1:0] unmasked;
   logic                   owner_req;

   // lowest set bit wins
   function automatic logic [NUM_MASTERS-1:0] pick_lowest(
      input logic [NUM_MASTERS-1:0] req
   );
      logic [NUM_MASTERS-1:0] one_hot;
      one_hot = '0;
      for (int i = NUM_MASTERS-1; i >= 0; i--) begin
         if (req[i]) begin
            one_hot    = '0;
            one_hot[i] = 1'b1;
         end
      end
      return one_hot;
   endfunction

   function automatic logic [MASTER_ID_W-1:0] encode(
      input logic [NUM_MASTERS-1:0] one_hot
   );
      logic [MASTER_ID_W-1:0] id;
      id = '0;
      for (int i = NUM_MASTERS-1; i >= 0; i--) begin
         if (one_hot[i]) id = MASTER_ID_W'(i);
      end
      return id;
   endfunction

   assign unmasked  = hbusreq & ~hmask;
   assign owner_req = |(hbusreq & hgrant);

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         hgrant    <= '0;
         hmaster   <= '0;
         hmastlock <= 1'b0;
         hmask     <= '0;
         state     <= ARB_READY;
      end else if (hready) begin
         hmaster   <= encode(hgrant);       // owner follows grant by one edge
         hmastlock <= |(hlock & hgrant);
         case (state)
            ARB_READY: begin
               if (|hbusreq) begin
                  hgrant <= pick_lowest(hbusreq);
                  hmask  <= '0;
                  state  <= ARB_STAY;
               end
            end
            ARB_STAY: begin
               if (hbusreq == '0) begin
                  hgrant <= '0;
                  hmask  <= '0;
                  state  <= ARB_READY;
               end else if (!owner_req) begin
                  if (unmasked == '0) begin   // everyone masked, plain priority
                     hgrant <= pick_lowest(hbusreq);
                     hmask  <= '0;
                  end else begin
                     hgrant <= pick_lowest(unmasked);
                     hmask  <= hmask | hgrant;   // old owner waits its turn
                  end
               end
            end
         endcase
      end
   end

endmodule

// ==== ahb_master_mux.sv ====
`timescale 1ns/1ns

module ahb_master_mux import ahb_pkg::*; (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  logic                   hready,
   input  logic [MASTER_ID_W-1:0] hmaster,
   input  ahb_ctrl_t              m_ctrl   [NUM_MASTERS],
   input  logic [DATA_W-1:0]      m_hwdata [NUM_MASTERS],
   output ahb_ctrl_t              s_ctrl,
   output logic [DATA_W-1:0]      s_hwdata
);

   logic [MASTER_ID_W-1:0] hmaster_d;   // owner of the data phase

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         hmaster_d <= '0;
      end else if (hready) begin
         hmaster_d <= hmaster;
      end
   end

   always_comb begin
      s_ctrl       = '0;
      s_ctrl.haddr = '1;   // no valid owner
      for (int i = 0; i < NUM_MASTERS; i++) begin
         if (hmaster == MASTER_ID_W'(i)) s_ctrl = m_ctrl[i];
      end
   end

   always_comb begin
      s_hwdata = '0;
      for (int i = 0; i < NUM_MASTERS; i++) begin
         if (hmaster_d == MASTER_ID_W'(i)) s_hwdata = m_hwdata[i];
      end
   end

endmodule

// ==== ahb_decoder.sv ====
`timescale 1ns/1ns

module ahb_decoder import ahb_pkg::*; (
   input  logic [ADDR_W-1:0]     haddr,
   input  logic                  remap,
   output logic [NUM_SLAVES-1:0] hsel,
   output logic                  hsel_default
);

   logic [NUM_SLAVES-1:0] hit;

   // --------------------
   // region compare
   always_comb begin
      for (int i = 0; i < NUM_SLAVES; i++) begin
         hit[i] = (haddr >= REGION_START[i]) &&
                  (haddr <  REGION_START[i] + REGION_SIZE[i]);
      end
   end

   // remap swaps slaves 0 and 1
   always_comb begin
      hsel = hit;
      if (remap) begin
         hsel[0] = hit[1];
         hsel[1] = hit[0];
      end
   end

   assign hsel_default = ~|hit;   // nothing mapped here

endmodule

// ==== ahb_response_mux.sv ====
`timescale 1ns/1ns

module ahb_response_mux import ahb_pkg::*; (
   input  logic                  HCLK,
   input  logic                  HRESETn,
   input  logic [NUM_SLAVES-1:0] hsel,
   input  logic                  hsel_default,
   input  ahb_resp_t             s_rsp [NUM_SLAVES],
   input  ahb_resp_t             default_rsp,
   output ahb_resp_t             m_rsp
);

   // top bit is the default slave
   logic [NUM_SLAVES:0] sel_q;

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         sel_q <= '0;
      end else if (m_rsp.hready) begin
         sel_q <= {hsel_default, hsel};   // select of the coming data phase
      end
   end

   // --------------------
   // data-phase routing
   always_comb begin
      m_rsp.hrdata = '0;          // empty select
      m_rsp.hresp  = RESP_ERROR;
      m_rsp.hready = 1'b1;        // must stay high or the bus locks up
      for (int i = 0; i < NUM_SLAVES; i++) begin
         if (sel_q == ({{NUM_SLAVES{1'b0}}, 1'b1} << i)) m_rsp = s_rsp[i];
      end
      if (sel_q == {1'b1, {NUM_SLAVES{1'b0}}}) m_rsp = default_rsp;
   end

endmodule

// ==== ahb_default_slave.sv ====
`timescale 1ns/1ns

module ahb_default_slave import ahb_pkg::*; (
   input  logic      HCLK,
   input  logic      HRESETn,
   input  logic      hsel,
   input  logic      hready,
   input  htrans_e   htrans,
   input  logic      hwrite,
   output ahb_resp_t rsp
);

   dslv_state_e state;
   hresp_e      resp_q;
   logic        ready_q;

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         state   <= DSLV_IDLE;
         resp_q  <= RESP_OKAY;
         ready_q <= 1'b1;
      end else begin
         case (state)
            DSLV_IDLE: begin
               resp_q  <= RESP_OKAY;
               ready_q <= 1'b1;
               if (hsel && hready) begin
                  case (htrans)
                     TRANS_NONSEQ, TRANS_SEQ: begin
                        resp_q  <= RESP_ERROR;   // first error cycle, stall
                        ready_q <= 1'b0;
                        state   <= hwrite ? DSLV_WRITE_ERR : DSLV_READ_ERR;
                     end
                     default: ;                  // idle/busy get OKAY
                  endcase
               end
            end
            DSLV_WRITE_ERR, DSLV_READ_ERR: begin
               resp_q  <= RESP_ERROR;   // second error cycle
               ready_q <= 1'b1;
               state   <= DSLV_IDLE;
            end
            default: begin
               resp_q  <= RESP_OKAY;
               ready_q <= 1'b1;
               state   <= DSLV_IDLE;
            end
         endcase
      end
   end

   assign rsp.hrdata = '0;   // nothing to read
   assign rsp.hresp  = resp_q;
   assign rsp.hready = ready_q;

endmodule

// ==== ahb_bus_m2s4.sv ====
`timescale 1ns/1ns

module ahb_bus_m2s4 import ahb_pkg::*; (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  logic [NUM_MASTERS-1:0] hbusreq,
   input  logic [NUM_MASTERS-1:0] hlock,
   input  ahb_ctrl_t              m_ctrl   [NUM_MASTERS],
   input  logic [DATA_W-1:0]      m_hwdata [NUM_MASTERS],
   input  logic                   remap,
   input  ahb_resp_t              s_rsp    [NUM_SLAVES],
   output logic [NUM_MASTERS-1:0] hgrant,
   output ahb_resp_t              m_rsp,
   output ahb_ctrl_t              s_ctrl,
   output logic [DATA_W-1:0]      s_hwdata,
   output logic                   s_hready,
   output logic [MASTER_ID_W-1:0] hmaster,
   output logic                   hmastlock,
   output logic [NUM_SLAVES-1:0]  hsel
);

   logic      hsel_default;
   ahb_resp_t default_rsp;

   assign s_hready = m_rsp.hready;   // shared bus ready

   ahb_arbiter u_arbiter (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .hbusreq   (hbusreq),
      .hlock     (hlock),
      .hready    (s_hready),
      .hgrant    (hgrant),
      .hmaster   (hmaster),
      .hmastlock (hmastlock)
   );

   ahb_master_mux u_master_mux (
      .HCLK     (HCLK),
      .HRESETn  (HRESETn),
      .hready   (s_hready),
      .hmaster  (hmaster),
      .m_ctrl   (m_ctrl),
      .m_hwdata (m_hwdata),
      .s_ctrl   (s_ctrl),
      .s_hwdata (s_hwdata)
   );

   // --------------------
   // slave side
   ahb_decoder u_decoder (
      .haddr        (s_ctrl.haddr),
      .remap        (remap),
      .hsel         (hsel),
      .hsel_default (hsel_default)
   );

   ahb_default_slave u_default_slave (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .hsel    (hsel_default),
      .hready  (s_hready),
      .htrans  (s_ctrl.htrans),
      .hwrite  (s_ctrl.hwrite),
      .rsp     (default_rsp)
   );

   ahb_response_mux u_response_mux (
      .HCLK         (HCLK),
      .HRESETn      (HRESETn),
      .hsel         (hsel),
      .hsel_default (hsel_default),
      .s_rsp        (s_rsp),
      .default_rsp  (default_rsp),
      .m_rsp        (m_rsp)
   );

endmodule

// ==== tb_ahb_bus.sv ====
`timescale 1ns/1ns

module tb_ahb_bus import ahb_pkg::*; ();

   logic                   HCLK;
   logic                   HRESETn;
   logic [NUM_MASTERS-1:0] hbusreq;
   logic [NUM_MASTERS-1:0] hlock;
   ahb_ctrl_t              m_ctrl   [NUM_MASTERS];
   logic [DATA_W-1:0]      m_hwdata [NUM_MASTERS];
   logic                   remap;
   ahb_resp_t              s_rsp    [NUM_SLAVES];
   logic [NUM_MASTERS-1:0] hgrant;
   ahb_resp_t              m_rsp;
   ahb_ctrl_t              s_ctrl;
   logic [DATA_W-1:0]      s_hwdata;
   logic                   s_hready;
   logic [MASTER_ID_W-1:0] hmaster;
   logic                   hmastlock;
   logic [NUM_SLAVES-1:0]  hsel;

   logic [1:0]             wait_cnt [NUM_SLAVES];   // wait states left
   logic [DATA_W-1:0]      word     [NUM_SLAVES];   // last word returned
   logic                   data_owner;              // master of the data phase

   ahb_bus_m2s4 DUT (.*);

   always #5 HCLK = ~HCLK;

   // --------------------
   // slave models
   always @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         for (int k = 0; k < NUM_SLAVES; k++) begin
            wait_cnt[k] <= 2'd0;
            word[k]     <= '0;
         end
      end else begin
         for (int k = 0; k < NUM_SLAVES; k++) begin
            if (wait_cnt[k] != 2'd0) begin
               wait_cnt[k] <= wait_cnt[k] - 2'd1;
            end else if (s_hready && hsel[k] && s_ctrl.htrans[1]) begin
               word[k] <= {8'(k), 24'($urandom)};   // slave number in top byte
               if (k == 2) wait_cnt[k] <= 2'($urandom_range(3, 0));
            end
         end
      end
   end

   always_comb begin
      for (int k = 0; k < NUM_SLAVES; k++) begin
         s_rsp[k].hrdata = word[k];
         s_rsp[k].hresp  = RESP_OKAY;
         s_rsp[k].hready = (wait_cnt[k] == 2'd0);
      end
   end

   always @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         data_owner <= 1'b0;
      end else if (s_hready) begin
         data_owner <= hmaster[0];
      end
   end

   // --------------------
   // check helpers
   task automatic stop_run();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("error %s expected %0h actual %0h", name, exp, act);
      stop_run();
   endtask

   task automatic report_event(input string what);
      $display("error %s", what);
      stop_run();
   endtask

   task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else report_mismatch(name, exp, act);
   endtask

   assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(hgrant))
      else report_event("grant, more than one master granted at once");
   assert property (@(posedge HCLK) disable iff (!HRESETn) !s_hready |=> $stable(hmaster))
      else report_event("stall, hmaster changed while hready was low");
   assert property (@(posedge HCLK) disable iff (!HRESETn) !s_hready |=> $stable(hgrant))
      else report_event("stall, hgrant changed while hready was low");
   assert property (@(posedge HCLK) disable iff (!HRESETn)
                    hmaster < MASTER_ID_W'(NUM_MASTERS))
      else report_event("control mux, hmaster does not name a master");
   assert property (@(posedge HCLK) disable iff (!HRESETn) s_ctrl == m_ctrl[hmaster[0]])
      else report_mismatch("control mux", $sampled(m_ctrl[hmaster[0]]),
                           $sampled(s_ctrl));
   assert property (@(posedge HCLK) disable iff (!HRESETn) s_hwdata == m_hwdata[data_owner])
      else report_mismatch("write data", $sampled(m_hwdata[data_owner]), $sampled(s_hwdata));
   assert property (@(posedge HCLK) disable iff (!HRESETn)
                    (!m_rsp.hready && m_rsp.hresp == RESP_ERROR) |=>
                    (m_rsp.hready && m_rsp.hresp == RESP_ERROR))
      else report_event("default slave, first error cycle not followed by ready with error");

   // --------------------
   // stimulus helpers
   task automatic next_cycle();
      @(negedge HCLK);
      for (int i = 0; i < NUM_MASTERS; i++) m_hwdata[i] = $urandom;
   endtask

   task automatic wait_ready(input string name);
      int n;
      n = 0;
      while (!s_hready) begin
         next_cycle();
         n++;
         if (n > 100) report_event($sformatf("timeout in %s, hready low for 100 cycles", name));
      end
   endtask

   task automatic step_ready(input string name);
      wait_ready(name);
      next_cycle();   // past one hready edge
   endtask

   function automatic logic [ADDR_W-1:0] region_addr(input int r);
      logic [ADDR_W-1:0] a;
      a = $urandom;
      case (r)
         0:       a[31:29] = 3'b000;
         1:       a[31:29] = 3'b001;
         2:       a[31:30] = 2'b01;
         3:       a[31:30] = 2'b10;
         default: a[31:30] = 2'b11;   // unmapped
      endcase
      return a;
   endfunction

   function automatic logic [NUM_SLAVES-1:0] expected_sel(input logic [ADDR_W-1:0] a,
                                                          input logic rm);
      logic [NUM_SLAVES-1:0] s;
      casez (a[31:29])
         3'b000:  s = 4'b0001;
         3'b001:  s = 4'b0010;
         3'b01?:  s = 4'b0100;
         3'b10?:  s = 4'b1000;
         default: s = 4'b0000;
      endcase
      if (rm) s = {s[3:2], s[0], s[1]};
      return s;
   endfunction

   task automatic read_check(input int k);
      int                     n;
      logic [MASTER_ID_W-1:0] owner;
      wait_ready("read address");
      owner = hmaster;
      m_ctrl[owner[0]].haddr  = region_addr(k);
      m_ctrl[owner[0]].htrans = TRANS_NONSEQ;
      m_ctrl[owner[0]].hwrite = 1'b0;
      m_ctrl[owner[0]].hsize  = 3'b010;
      next_cycle();
      m_ctrl[owner[0]].htrans = TRANS_IDLE;
      n = 0;
      while (wait_cnt[k] != 2'd0) begin   // wait states of the slave model
         expect_eq("wait state hready", 32'd0, 32'(m_rsp.hready));
         expect_eq("wait state bus ready", 32'd0, 32'(s_hready));
         expect_eq("wait state owner", 32'(owner), 32'(hmaster));
         next_cycle();
         n++;
         if (n > 100) report_event("timeout in read data phase, wait states did not end");
      end
      expect_eq("read ready", 32'd1, 32'(s_hready));
      expect_eq("read slave id", 32'(k), 32'(m_rsp.hrdata[31:24]));
      expect_eq("read data", word[k], m_rsp.hrdata);
      expect_eq("read resp", 32'(RESP_OKAY), 32'(m_rsp.hresp));
   endtask

   // --------------------
   // test sequence
   initial begin
      logic [ADDR_W-1:0] addr;
      void'($urandom(37647));
      HCLK    = 1'b0;
      HRESETn = 1'b0;
      hbusreq = '0;
      hlock   = '0;
      remap   = 1'b0;
      for (int i = 0; i < NUM_MASTERS; i++) begin
         m_ctrl[i]   = '0;
         m_hwdata[i] = '0;
      end
      repeat (3) @(posedge HCLK);
      @(negedge HCLK);
      HRESETn = 1'b1;

      hbusreq = 2'b11;   // both request from idle
      hlock   = 2'b01;
      step_ready("priority grant");
      expect_eq("priority grant", 32'(2'b01), 32'(hgrant));
      step_ready("priority owner");
      expect_eq("priority owner", 32'd0, 32'(hmaster));
      expect_eq("priority lock", 32'(hlock[0]), 32'(hmastlock));

      for (int r = 0; r < 5; r++) begin
         for (int j = 0; j < 8; j++) begin
            addr            = region_addr(r);
            m_ctrl[0].haddr = addr;
            remap           = j[0];
            #1;
            expect_eq("decode", 32'(expected_sel(addr, remap)), 32'(hsel));
            next_cycle();
         end
      end
      remap = 1'b0;

      for (int k = 0; k < NUM_SLAVES; k++) read_check(k);
      for (int j = 0; j < 6; j++) read_check(2);

      wait_ready("error address");
      m_ctrl[0].haddr  = region_addr(4);
      m_ctrl[0].htrans = TRANS_NONSEQ;
      next_cycle();
      m_ctrl[0].htrans = TRANS_IDLE;
      expect_eq("error cycle 1 hready", 32'd0, 32'(m_rsp.hready));
      expect_eq("error cycle 1 hresp", 32'(RESP_ERROR), 32'(m_rsp.hresp));
      next_cycle();
      expect_eq("error cycle 2 hready", 32'd1, 32'(m_rsp.hready));
      expect_eq("error cycle 2 hresp", 32'(RESP_ERROR), 32'(m_rsp.hresp));
      step_ready("idle unmapped");
      step_ready("idle unmapped");   // idle seen by the default slave itself
      expect_eq("idle unmapped hready", 32'd1, 32'(m_rsp.hready));
      expect_eq("idle unmapped hresp", 32'(RESP_OKAY), 32'(m_rsp.hresp));

      hbusreq = 2'b10;   // owner lets go
      step_ready("handover grant");
      expect_eq("handover grant", 32'(2'b10), 32'(hgrant));
      step_ready("handover owner");
      expect_eq("handover owner", 32'd1, 32'(hmaster));
      expect_eq("handover lock", 32'(hlock[1]), 32'(hmastlock));
      wait_ready("write address");
      m_ctrl[1].haddr  = region_addr(3);
      m_ctrl[1].htrans = TRANS_NONSEQ;
      m_ctrl[1].hwrite = 1'b1;
      next_cycle();
      m_ctrl[1].htrans = TRANS_IDLE;
      step_ready("write data");
      hbusreq = 2'b01;
      step_ready("regrant");
      expect_eq("regrant", 32'(2'b01), 32'(hgrant));
      hbusreq = 2'b00;
      step_ready("release");
      expect_eq("release grant", 32'd0, 32'(hgrant));

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== vlog.f ====
ahb_pkg.sv
ahb_arbiter.sv
ahb_master_mux.sv
ahb_decoder.sv
ahb_response_mux.sv
ahb_default_slave.sv
ahb_bus_m2s4.sv
tb_ahb_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_ahb_bus -f vlog.f -o sim_tb &&
./obj_dir/sim_tb | awk '{ print } /^RESULT: PASS$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
